//--- sace_defs.svh
`ifndef SACE_DEFS_SVH
`define SACE_DEFS_SVH

// spam bus widths.
`define SPAM_DID_W 4
`define SPAM_ADDR_W 24
`define SPAM_DATA_W 32

// device id claimed by the systemace bridge.
`define SPAM_DID_SACE 4'h3

// systemace microprocessor port.
`define SACE_ADDR_W 7
`define SACE_WORD_W 16

`endif

//--- spam_pkg.sv
`include "sace_defs.svh"

package spam_pkg;

	// target device on the bus.
	typedef logic [`SPAM_DID_W-1:0] spam_did_t;

	// byte address, word aligned by the requester.
	typedef logic [`SPAM_ADDR_W-1:0] spam_addr_t;

	typedef logic [`SPAM_DATA_W-1:0] spam_data_t;

	// request as driven by the bus master.
	typedef struct packed {
		logic       valid;
		logic       r_nw;
		spam_did_t  did;
		spam_addr_t addr;
		spam_data_t wrdata;
	} spam_req_t;

	// done is a single-cycle pulse.
	typedef struct packed {
		logic       done;
		spam_data_t rddata;
	} spam_rsp_t;

endpackage

//--- sace_pkg.sv
`include "sace_defs.svh"

package sace_pkg;

	// register address on the mpu port.
	typedef logic [`SACE_ADDR_W-1:0] sace_addr_t;

	// data word on the mpu port.
	typedef logic [`SACE_WORD_W-1:0] sace_word_t;

	// request bundle handed from core_clk to sace_clk.
	// req_tgl flips once per request, the rest is held with it.
	typedef struct packed {
		logic       req_tgl;
		logic       r_nw;
		sace_addr_t addr;
		sace_word_t wrdata;
	} sace_cmd_t;

	// strobe sequencer.
	typedef enum logic {
		SACE_IDLE,
		SACE_STROBE
	} sace_state_t;

endpackage

//--- spam_sace_req_port.sv
`timescale 1ns/1ns

`include "sace_defs.svh"

module spam_sace_req_port
	import spam_pkg::*, sace_pkg::*;
(
	input  logic       core_clk,
	input  logic       sace_rst_b,
	input  spam_req_t  spam_req,
	output sace_cmd_t  cmd,
	input  logic       done_tgl,
	input  sace_word_t rd_word,
	output spam_rsp_t  spam_rsp
);

	localparam int PAD_W = `SPAM_DATA_W - `SACE_WORD_W;

	logic [1:0] core_rst_sync;
	logic       core_rst_b;
	logic       req_hit;

	logic       done_meta;
	logic       done_sync;
	logic       done_q;
	logic       done_qq;
	logic       done_edge;

	sace_word_t rd_meta;
	sace_word_t rd_sync;

	// async assert, release on core_clk.
	always_ff @(posedge core_clk or negedge sace_rst_b) begin
		if (!sace_rst_b) begin
			core_rst_sync <= 2'b00;
		end else begin
			core_rst_sync <= {core_rst_sync[0], 1'b1};
		end
	end

	assign core_rst_b = core_rst_sync[1];

	// only our device id is taken.
	assign req_hit = spam_req.valid && (spam_req.did == spam_did_t'(`SPAM_DID_SACE));

	// bundle stays put until the next accepted request.
	always_ff @(posedge core_clk or negedge core_rst_b) begin
		if (!core_rst_b) begin
			cmd <= '0;
		end else if (req_hit) begin
			cmd.req_tgl <= ~cmd.req_tgl;
			cmd.r_nw    <= spam_req.r_nw;
			cmd.addr    <= spam_req.addr[8:2];
			cmd.wrdata  <= spam_req.wrdata[`SACE_WORD_W-1:0];
		end
	end

	// completion toggle from sace_clk.
	always_ff @(posedge core_clk or negedge core_rst_b) begin
		if (!core_rst_b) begin
			done_meta <= 1'b0;
			done_sync <= 1'b0;
			done_q    <= 1'b0;
			done_qq   <= 1'b0;
		end else begin
			done_meta <= done_tgl;
			done_sync <= done_meta;
			done_q    <= done_sync;
			done_qq   <= done_q;
		end
	end

	// read word settles well ahead of the toggle edge.
	always_ff @(posedge core_clk) begin
		rd_meta <= rd_word;
		rd_sync <= rd_meta;
	end

	assign done_edge = done_q ^ done_qq;

	always_ff @(posedge core_clk or negedge core_rst_b) begin
		if (!core_rst_b) begin
			spam_rsp <= '0;
		end else begin
			spam_rsp.done   <= done_edge;
			spam_rsp.rddata <= done_edge ? {{PAD_W{1'b0}}, rd_sync} : '0;
		end
	end

endmodule

//--- sace_req_sync.sv
`timescale 1ns/1ns

module sace_req_sync
	import sace_pkg::*;
(
	input  logic      sace_clk,
	input  logic      sace_rst_b,
	input  sace_cmd_t cmd,
	output sace_cmd_t cmd_sync,
	output logic      req_tgl_d,
	output logic      sace_rst_sync_b
);

	logic [2:0] rst_sync;
	sace_cmd_t  cmd_meta;

	// three flops for the sace side reset.
	always_ff @(posedge sace_clk or negedge sace_rst_b) begin
		if (!sace_rst_b) begin
			rst_sync <= 3'b000;
		end else begin
			rst_sync <= {rst_sync[1:0], 1'b1};
		end
	end

	assign sace_rst_sync_b = rst_sync[2];

	// whole bundle crosses together.
	// fields are stable long before the toggle is acted on.
	always_ff @(posedge sace_clk or negedge sace_rst_sync_b) begin
		if (!sace_rst_sync_b) begin
			cmd_meta <= '0;
			cmd_sync <= '0;
		end else begin
			cmd_meta <= cmd;
			cmd_sync <= cmd_meta;
		end
	end

	// extra stage so the payload has settled when a new toggle shows.
	always_ff @(posedge sace_clk or negedge sace_rst_sync_b) begin
		if (!sace_rst_sync_b) begin
			req_tgl_d <= 1'b0;
		end else begin
			req_tgl_d <= cmd_sync.req_tgl;
		end
	end

endmodule

//--- sace_mpu_ctrl.sv
`timescale 1ns/1ns

module sace_mpu_ctrl
	import sace_pkg::*;
(
	input  logic       sace_clk,
	input  logic       sace_rst_sync_b,
	input  sace_cmd_t  cmd_sync,
	input  logic       req_tgl_d,
	output sace_addr_t mpa,
	output sace_word_t mpd_out,
	input  sace_word_t mpd_in,
	output logic       mpd_oe,
	output logic       mpce_n,
	output logic       mpwe_n,
	output logic       mpoe_n,
	output logic       done_tgl,
	output sace_word_t rd_word
);

	sace_state_t state;
	logic        pending;

	// a request is open until done_tgl catches up.
	assign pending = done_tgl != req_tgl_d;

	assign mpce_n  = ~pending;
	assign mpa     = cmd_sync.addr;
	assign mpd_out = cmd_sync.wrdata;

	// drive the data bus for the whole write access.
	assign mpd_oe  = pending && !cmd_sync.r_nw;

	always_ff @(posedge sace_clk or negedge sace_rst_sync_b) begin
		if (!sace_rst_sync_b) begin
			state    <= SACE_IDLE;
			mpwe_n   <= 1'b1;
			mpoe_n   <= 1'b1;
			done_tgl <= 1'b0;
		end else begin
			case (state)
				SACE_IDLE: begin
					if (pending) begin
						if (cmd_sync.r_nw) begin
							mpoe_n <= 1'b0;
						end else begin
							mpwe_n <= 1'b0;
						end
						state <= SACE_STROBE;
					end
				end
				SACE_STROBE: begin
					// one cycle of strobe, then close out.
					mpwe_n   <= 1'b1;
					mpoe_n   <= 1'b1;
					done_tgl <= req_tgl_d;
					state    <= SACE_IDLE;
				end
				default: begin
					state <= SACE_IDLE;
				end
			endcase
		end
	end

	// sample read data as output enable is released.
	always_ff @(posedge sace_clk or negedge sace_rst_sync_b) begin
		if (!sace_rst_sync_b) begin
			rd_word <= '0;
		end else if (state == SACE_STROBE && cmd_sync.r_nw) begin
			rd_word <= mpd_in;
		end
	end

endmodule

//--- sace_bridge.sv
`timescale 1ns/1ns

module sace_bridge
	import spam_pkg::*, sace_pkg::*;
(
	input  logic       core_clk,
	input  logic       sace_clk,
	input  logic       sace_rst_b,
	input  spam_req_t  spam_req,
	output spam_rsp_t  spam_rsp,
	output sace_addr_t mpa,
	output sace_word_t mpd_out,
	input  sace_word_t mpd_in,
	output logic       mpd_oe,
	output logic       mpce_n,
	output logic       mpwe_n,
	output logic       mpoe_n
);

	sace_cmd_t  cmd;
	sace_cmd_t  cmd_sync;
	logic       req_tgl_d;
	logic       sace_rst_sync_b;
	logic       done_tgl;
	sace_word_t rd_word;

	// core_clk side.
	spam_sace_req_port u_req_port (
		.core_clk   (core_clk),
		.sace_rst_b (sace_rst_b),
		.spam_req   (spam_req),
		.cmd        (cmd),
		.done_tgl   (done_tgl),
		.rd_word    (rd_word),
		.spam_rsp   (spam_rsp)
	);

	// into sace_clk.
	sace_req_sync u_req_sync (
		.sace_clk        (sace_clk),
		.sace_rst_b      (sace_rst_b),
		.cmd             (cmd),
		.cmd_sync        (cmd_sync),
		.req_tgl_d       (req_tgl_d),
		.sace_rst_sync_b (sace_rst_sync_b)
	);

	sace_mpu_ctrl u_mpu_ctrl (
		.sace_clk        (sace_clk),
		.sace_rst_sync_b (sace_rst_sync_b),
		.cmd_sync        (cmd_sync),
		.req_tgl_d       (req_tgl_d),
		.mpa             (mpa),
		.mpd_out         (mpd_out),
		.mpd_in          (mpd_in),
		.mpd_oe          (mpd_oe),
		.mpce_n          (mpce_n),
		.mpwe_n          (mpwe_n),
		.mpoe_n          (mpoe_n),
		.done_tgl        (done_tgl),
		.rd_word         (rd_word)
	);

endmodule

//--- sace_bridge_assertions.sv
`timescale 1ns/1ns

module sace_bridge_assertions (
	input logic sace_clk,
	input logic sace_rst_sync_b,
	input logic mpce_n,
	input logic mpwe_n,
	input logic mpoe_n
);

	// write and read strobes are exclusive.
	a_one_strobe: assert property (@(posedge sace_clk) disable iff (!sace_rst_sync_b)
		!(!mpwe_n && !mpoe_n))
		else $error("mpwe_n and mpoe_n low together");

	// strobes only inside chip enable.
	a_strobe_in_ce: assert property (@(posedge sace_clk) disable iff (!sace_rst_sync_b)
		(!mpwe_n || !mpoe_n) |-> !mpce_n)
		else $error("strobe low while mpce_n high");

	// single-cycle strobes.
	a_we_width: assert property (@(posedge sace_clk) disable iff (!sace_rst_sync_b)
		!mpwe_n |=> mpwe_n)
		else $error("mpwe_n low for more than one cycle");

	a_oe_width: assert property (@(posedge sace_clk) disable iff (!sace_rst_sync_b)
		!mpoe_n |=> mpoe_n)
		else $error("mpoe_n low for more than one cycle");

endmodule

bind sace_mpu_ctrl sace_bridge_assertions u_assertions (
	.sace_clk        (sace_clk),
	.sace_rst_sync_b (sace_rst_sync_b),
	.mpce_n          (mpce_n),
	.mpwe_n          (mpwe_n),
	.mpoe_n          (mpoe_n)
);

//--- sace_bridge_tb.sv
`timescale 1ns/1ns

`include "sace_defs.svh"

module sace_bridge_tb
	import spam_pkg::*, sace_pkg::*;
();

	localparam int N_WR = 32;
	localparam int N_RD = 32;
	localparam int N_IGN = 8;
	localparam int N_MIX = 200;
	localparam int DONE_LIMIT = 40;
	localparam int RESET_NS = 4 * 8 + 60;
	localparam int WATCHDOG_NS = RESET_NS + (N_WR + N_RD + N_IGN + N_MIX) * 400;

	logic       core_clk;
	logic       sace_clk;
	logic       sace_rst_b;
	spam_req_t  spam_req;
	spam_rsp_t  spam_rsp;
	sace_addr_t mpa;
	sace_word_t mpd_out;
	sace_word_t mpd_in;
	logic       mpd_oe;
	logic       mpce_n;
	logic       mpwe_n;
	logic       mpoe_n;

	// systemace register file and its predicted contents.
	sace_word_t mem [128];
	sace_word_t sb [128];
	sace_word_t snap [128];
	sace_addr_t written [$];

	int          err_cnt = 0;
	int          fail_tests = 0;
	int          strobe_cnt = 0;

	sace_bridge UUT (
		.core_clk   (core_clk),
		.sace_clk   (sace_clk),
		.sace_rst_b (sace_rst_b),
		.spam_req   (spam_req),
		.spam_rsp   (spam_rsp),
		.mpa        (mpa),
		.mpd_out    (mpd_out),
		.mpd_in     (mpd_in),
		.mpd_oe     (mpd_oe),
		.mpce_n     (mpce_n),
		.mpwe_n     (mpwe_n),
		.mpoe_n     (mpoe_n)
	);

	initial begin
		sace_clk = 1'b0;
		forever #4 sace_clk = ~sace_clk;
	end

	initial begin
		core_clk = 1'b0;
		forever #5 core_clk = ~core_clk;
	end

	// every bit of the address shows up in the word.
	function automatic sace_word_t fill_word(input sace_addr_t a);
		return {a, 2'b10, ~a};
	endfunction

	// write lands on the edge that ends the write strobe.
	always @(posedge sace_clk) begin
		if (!mpce_n && !mpwe_n) begin
			if (mpd_oe !== 1'b1) begin
				report_value("mpd_oe", {31'h0, mpd_oe}, 32'h1);
			end
			mem[mpa] = mpd_out;
		end
		// the model drives the bus during a read.
		if (!mpoe_n && mpd_oe !== 1'b0) begin
			report_value("mpd_oe", {31'h0, mpd_oe}, 32'h0);
		end
		if (!mpwe_n || !mpoe_n) begin
			strobe_cnt = strobe_cnt + 1;
		end
	end

	assign mpd_in = !mpoe_n ? mem[mpa] : 16'h0000;

	task automatic report_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
		err_cnt++;
	endtask

	task automatic report_error(input string what);
		$display("error at t=%0t: %s", $time, what);
		err_cnt++;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		int errs;
		errs = err_cnt - errs_before;
		if (errs != 0) begin
			fail_tests++;
		end
		$display("test %-8s done, %0d errors", name, errs);
	endtask

	function automatic spam_addr_t rand_addr(input sace_addr_t idx);
		logic [31:0] r;
		r = $urandom;
		return {r[14:0], idx, 2'b00};
	endfunction

	task automatic send_req(input logic r_nw, input spam_did_t did, input spam_addr_t addr,
			input spam_data_t data);
		@(negedge core_clk);
		spam_req.valid = 1'b1;
		spam_req.r_nw = r_nw;
		spam_req.did = did;
		spam_req.addr = addr;
		spam_req.wrdata = data;
		@(negedge core_clk);
		spam_req.valid = 1'b0;
	endtask

	task automatic wait_done(output spam_data_t rdata, output logic seen);
		int n;
		seen = 1'b0;
		rdata = '0;
		n = 0;
		while (!seen && n < DONE_LIMIT) begin
			@(negedge core_clk);
			n++;
			if (spam_rsp.done) begin
				seen = 1'b1;
				rdata = spam_rsp.rddata;
			end else if (spam_rsp.rddata !== 32'h0) begin
				report_value("spam_rsp.rddata", spam_rsp.rddata, 32'h0);
			end
		end
		if (!seen) begin
			report_error("no done pulse after a request");
		end else begin
			@(negedge core_clk);
			if (spam_rsp.done !== 1'b0) begin
				report_error("done pulse longer than one core_clk cycle");
			end
		end
	endtask

	task automatic run_access(input logic r_nw, input spam_addr_t addr, input spam_data_t data);
		sace_addr_t idx;
		spam_data_t rdata;
		logic       seen;
		idx = addr[8:2];
		send_req(r_nw, `SPAM_DID_SACE, addr, data);
		wait_done(rdata, seen);
		if (seen && r_nw) begin
			if (rdata !== {16'h0000, sb[idx]}) begin
				report_value("spam_rsp.rddata", rdata, {16'h0000, sb[idx]});
			end
		end else if (seen) begin
			sb[idx] = data[15:0];
			written.push_back(idx);
			if (mem[idx] !== sb[idx]) begin
				report_value("model word", {16'h0000, mem[idx]}, {16'h0000, sb[idx]});
			end
		end
	endtask

	initial begin
		spam_did_t   did;
		logic [31:0] r;
		int          errs_before;
		int          strobes_before;
		logic        same;

		void'($urandom(13));
		spam_req = '0;
		sace_rst_b = 1'b0;
		for (int i = 0; i < 128; i++) begin
			mem[7'(i)] = fill_word(7'(i));
			sb[7'(i)] = fill_word(7'(i));
		end
		repeat (4) @(posedge sace_clk);
		@(negedge sace_clk);
		sace_rst_b = 1'b1;
		repeat (6) @(negedge core_clk);

		errs_before = err_cnt;
		if (mpce_n !== 1'b1) begin
			report_value("mpce_n", {31'h0, mpce_n}, 32'h1);
		end
		if (mpwe_n !== 1'b1) begin
			report_value("mpwe_n", {31'h0, mpwe_n}, 32'h1);
		end
		if (mpoe_n !== 1'b1) begin
			report_value("mpoe_n", {31'h0, mpoe_n}, 32'h1);
		end
		if (mpd_oe !== 1'b0) begin
			report_value("mpd_oe", {31'h0, mpd_oe}, 32'h0);
		end
		if (spam_rsp.done !== 1'b0) begin
			report_value("spam_rsp.done", {31'h0, spam_rsp.done}, 32'h0);
		end
		finish_test("reset", errs_before);

		errs_before = err_cnt;
		for (int k = 0; k < N_WR; k++) begin
			r = $urandom;
			run_access(1'b0, rand_addr(r[6:0]), $urandom);
		end
		finish_test("write", errs_before);

		errs_before = err_cnt;
		for (int k = 0; k < N_RD; k++) begin
			run_access(1'b1, rand_addr(written[$urandom_range(written.size() - 1, 0)]),
				$urandom);
		end
		finish_test("read", errs_before);

		// other device ids must leave the port alone.
		errs_before = err_cnt;
		snap = mem;
		strobes_before = strobe_cnt;
		for (int k = 0; k < N_IGN; k++) begin
			r = $urandom;
			did = r[3:0];
			if (did == `SPAM_DID_SACE) begin
				did = did + 4'h1;
			end
			send_req(r[4], did, rand_addr(r[11:5]), $urandom);
		end
		for (int k = 0; k < 100; k++) begin
			@(negedge core_clk);
			if (spam_rsp.done !== 1'b0) begin
				report_error("done pulse for another device id");
			end
		end
		if (strobe_cnt != strobes_before) begin
			report_error("port strobe for another device id");
		end
		same = 1'b1;
		for (int i = 0; i < 128; i++) begin
			if (mem[7'(i)] !== snap[7'(i)]) begin
				same = 1'b0;
			end
		end
		if (!same) begin
			report_error("model contents changed by another device id");
		end
		finish_test("ignore", errs_before);

		errs_before = err_cnt;
		for (int k = 0; k < N_MIX; k++) begin
			r = $urandom;
			run_access(r[7], rand_addr(r[6:0]), $urandom);
		end
		finish_test("mix", errs_before);

		$display("tests 5, failed tests %0d, errors %0d", fail_tests, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests completed");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- sace_bridge.f
+incdir+.
spam_pkg.sv
sace_pkg.sv
spam_sace_req_port.sv
sace_req_sync.sv
sace_mpu_ctrl.sv
sace_bridge.sv
sace_bridge_assertions.sv
sace_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run with verilator, then look for the fail message in the log.
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert --top-module sace_bridge_tb -f sace_bridge.f \
	-o sace_bridge_sim && ./obj_dir/sace_bridge_sim; } > sim.log 2>&1 \
	|| echo "Simulation FAILED" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0
